// File: hdl/mcb_consts.svh
// Shared constants for the UART-controlled bus master
// Bit period is in system clocks, no baud generator
// MCB_SLAVES must stay within 1..16
// CSR addresses are 8 bits, unmapped ones read as zero

`ifndef MCB_CONSTS_SVH
`define MCB_CONSTS_SVH

// UART timing
`define MCB_CLKS_PER_BIT   16

// Bus geometry
`define MCB_BUS_ADRS_BITS  16
`define MCB_BUS_DATA_BITS  32
`define MCB_SLAVES         4

// Host command and reply codes (ASCII)
`define MCB_CMD_WRITE      8'h57
`define MCB_CMD_READ       8'h52
`define MCB_REPLY_ACK      8'h4B
`define MCB_REPLY_ERR      8'h45

// CSR map
`define MCB_CSR_BUS_ADRS   8'h00
`define MCB_CSR_BUS_WD     8'h01
`define MCB_CSR_SCRATCH    8'h02
`define MCB_CSR_AUTO_RD    8'h04
`define MCB_CSR_RD_FLAGS   8'h05

`endif

// File: hdl/McbPkg.sv
// Types shared by the bus master blocks
// Widths come from the constants header

`default_nettype none

`include "mcb_consts.svh"

package McbPkg;

	// Plain vectors with a meaning
	typedef logic [`MCB_BUS_DATA_BITS-1:0] busData_t;
	typedef logic [`MCB_BUS_ADRS_BITS-1:0] busAdrs_t;
	typedef logic [`MCB_SLAVES-1:0]        slaveMask_t;
	typedef logic [7:0]                    csrAdrs_t;
	typedef logic [7:0]                    uartByte_t;

	// Parser to CSR access, one cke cycle per access
	typedef struct packed {
		busData_t wd;
		csrAdrs_t adrs;
		logic     write;
		logic     cke;
	} csrCmd_t;

	// Master side of the internal bus
	typedef struct packed {
		busData_t wd;
		busAdrs_t adrs;
		logic     wEd;
	} busWrite_t;

	// Command parser FSM
	typedef enum logic [2:0] {Idle, Adrs, Data, Access, Reply, Wait} parserState_t;

endpackage

`default_nettype wire

// File: hdl/UartRx.sv
// UART receiver, 8N1, LSB first
// No parity, stop bit is not checked
// A start bit that is high again at mid-bit is dropped as a glitch

`timescale 1ns/100ps
`default_nettype none

`include "mcb_consts.svh"

module UartRx (
	input  logic              sysClk,
	input  logic              reset,
	input  logic              rx,
	output McbPkg::uartByte_t rxByte,
	output logic              rxValid
);
	import McbPkg::*;

	// [0] meta, [1] synced, [2] synced delayed for edge detect
	logic [2:0] lineSync;
	logic busy;
	logic [$clog2(`MCB_CLKS_PER_BIT)-1:0] clkCnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bitIdx;
	logic bitTick;
	uartByte_t shiftReg;

	// Half a bit to reach mid start, full bits afterwards
	assign bitTick = (bitIdx == 4'd0) ?
		(clkCnt == `MCB_CLKS_PER_BIT / 2 - 1) :
		(clkCnt == `MCB_CLKS_PER_BIT - 1);

	//----------------------------------------------------------
	// Bit timing and framing
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			lineSync <= 3'b111;
			busy     <= 1'b0;
			clkCnt   <= '0;
			bitIdx   <= '0;
			rxValid  <= 1'b0;
		end
		else
		begin
			lineSync <= {lineSync[1:0], rx};
			rxValid  <= 1'b0;
			if (!busy)
			begin
				clkCnt <= '0;
				bitIdx <= '0;
				// Falling edge means start bit
				if (lineSync[2] && !lineSync[1])
					busy <= 1'b1;
			end
			else if (!bitTick)
				clkCnt <= clkCnt + 1'b1;
			else
			begin
				clkCnt <= '0;
				bitIdx <= bitIdx + 1'b1;
				if (bitIdx == 4'd0 && lineSync[1])
					busy <= 1'b0;
				else if (bitIdx == 4'd9)
				begin
					// Mid stop bit, byte complete
					rxValid <= 1'b1;
					busy    <= 1'b0;
				end
			end
		end
	end

	// Data bits enter at the top, LSB ends at bit 0
	always_ff @(posedge sysClk)
	begin
		if (busy && bitTick && bitIdx >= 4'd1 && bitIdx <= 4'd8)
			shiftReg <= {lineSync[1], shiftReg[7:1]};
	end

	assign rxByte = shiftReg;

	// One strobe per byte
	assert property (@(posedge sysClk) disable iff (reset) rxValid |=> !rxValid);

endmodule

`default_nettype wire

// File: hdl/UartTx.sv
// UART transmitter, 8N1, LSB first
// txStart is taken only while txBusy is low
// txBusy rises the cycle after the strobe, falls after the stop bit

`timescale 1ns/100ps
`default_nettype none

`include "mcb_consts.svh"

module UartTx (
	input  logic              sysClk,
	input  logic              reset,
	input  McbPkg::uartByte_t txByte,
	input  logic              txStart,
	output logic              tx,
	output logic              txBusy
);

	// Stop, data, start; bit 0 drives the line
	logic [9:0] frame;
	logic [$clog2(`MCB_CLKS_PER_BIT)-1:0] clkCnt;
	logic [3:0] bitCnt;

	//----------------------------------------------------------
	// Shift out
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			// All ones keeps the line idle high
			frame  <= '1;
			txBusy <= 1'b0;
			clkCnt <= '0;
			bitCnt <= '0;
		end
		else if (!txBusy)
		begin
			if (txStart)
			begin
				frame  <= {1'b1, txByte, 1'b0};
				txBusy <= 1'b1;
				clkCnt <= '0;
				bitCnt <= '0;
			end
		end
		else if (clkCnt == `MCB_CLKS_PER_BIT - 1)
		begin
			clkCnt <= '0;
			// Ones fill in behind, line ends high
			frame  <= {1'b1, frame[9:1]};
			bitCnt <= bitCnt + 1'b1;
			if (bitCnt == 4'd9)
				txBusy <= 1'b0;
		end
		else
			clkCnt <= clkCnt + 1'b1;
	end

	assign tx = frame[0];

	// Parser must respect busy, a strobe during a frame is lost
	assert property (@(posedge sysClk) disable iff (reset) txStart |-> !txBusy);

endmodule

`default_nettype wire

// File: hdl/McbCommandParser.sv
// Host command parser, stands in for a soft-core CPU
// Frames: 'W' adrs d3 d2 d1 d0 -> 'K', 'R' adrs -> 4 bytes MSB first
// Unknown opcode -> 'E'; bytes received during a reply are dropped
// No timeout, a partial frame waits for its remaining bytes

`timescale 1ns/100ps
`default_nettype none

`include "mcb_consts.svh"

module McbCommandParser (
	input  logic              sysClk,
	input  logic              reset,
	input  McbPkg::uartByte_t rxByte,
	input  logic              rxValid,
	output McbPkg::csrCmd_t   csrCmd,
	input  McbPkg::busData_t  csrRd,
	output McbPkg::uartByte_t txByte,
	output logic              txStart,
	input  logic              txBusy
);
	import McbPkg::*;

	parserState_t state;
	logic isWrite;
	logic ckeReg;
	// Data byte count while collecting, bytes left while replying
	logic [1:0] byteCnt;
	csrAdrs_t adrsReg;
	// Write data shift register, reused as reply buffer
	busData_t frameBuf;

	//----------------------------------------------------------
	// Command FSM
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			state   <= Idle;
			isWrite <= 1'b0;
			ckeReg  <= 1'b0;
			byteCnt <= '0;
			txStart <= 1'b0;
		end
		else
		begin
			ckeReg  <= 1'b0;
			txStart <= 1'b0;
			case (state)
				Idle:
				begin
					if (rxValid)
					begin
						if (rxByte == `MCB_CMD_WRITE || rxByte == `MCB_CMD_READ)
						begin
							isWrite <= (rxByte == `MCB_CMD_WRITE);
							state   <= Adrs;
						end
						else
						begin
							// Single error byte
							byteCnt <= '0;
							state   <= Reply;
						end
					end
				end
				Adrs:
				begin
					if (rxValid)
					begin
						byteCnt <= '0;
						if (isWrite)
							state <= Data;
						else
						begin
							// Read frame complete
							ckeReg <= 1'b1;
							state  <= Access;
						end
					end
				end
				Data:
				begin
					if (rxValid)
					begin
						byteCnt <= byteCnt + 1'b1;
						if (byteCnt == 2'd3)
						begin
							ckeReg <= 1'b1;
							state  <= Access;
						end
					end
				end
				Access:
				begin
					// Cycle after cke, csrRd now valid
					if (!ckeReg)
					begin
						byteCnt <= isWrite ? 2'd0 : 2'd3;
						state   <= Reply;
					end
				end
				Reply:
				begin
					if (!txBusy)
					begin
						txStart <= 1'b1;
						state   <= Wait;
					end
				end
				Wait:
				begin
					// Hold until the transmitter has taken the byte
					if (txBusy)
					begin
						if (byteCnt == 2'd0)
							state <= Idle;
						else
						begin
							byteCnt <= byteCnt - 1'b1;
							state   <= Reply;
						end
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	//----------------------------------------------------------
	// Payload, address and data or reply bytes
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (state == Idle && rxValid)
			frameBuf <= {`MCB_REPLY_ERR, 24'h0};
		else if (state == Adrs && rxValid)
			adrsReg <= rxByte;
		else if (state == Data && rxValid)
			frameBuf <= {frameBuf[23:0], rxByte};
		else if (state == Access && !ckeReg)
			frameBuf <= isWrite ? {`MCB_REPLY_ACK, 24'h0} : csrRd;
		else if (state == Wait && txBusy)
			frameBuf <= {frameBuf[23:0], 8'h00};
	end

	assign txByte = frameBuf[31:24];

	always_comb
	begin
		csrCmd.wd    = frameBuf;
		csrCmd.adrs  = adrsReg;
		csrCmd.write = isWrite;
		csrCmd.cke   = ckeReg;
	end

	// One access per frame
	assert property (@(posedge sysClk) disable iff (reset) csrCmd.cke |=> !csrCmd.cke);

endmodule

`default_nettype wire

// File: hdl/MicroControllerCsr.sv
// CSR space of the bus master
// Writing BUS_WD fires one bus write at the held BUS_ADRS
// Slaves push data unasked
// Read flags stay set until written
// No slave address decode here

`timescale 1ns/100ps
`default_nettype none

`include "mcb_consts.svh"

module MicroControllerCsr (
	input  logic               sysClk,
	input  logic               reset,
	input  McbPkg::csrCmd_t    csrCmd,
	output McbPkg::busData_t   csrRd,
	input  McbPkg::busData_t   muRd,
	input  McbPkg::slaveMask_t muREd,
	output McbPkg::busWrite_t  busWr
);
	import McbPkg::*;

	busAdrs_t   busAdrsReg;
	busData_t   busWdReg;
	busData_t   scratchReg;
	busData_t   autoRdReg;
	slaveMask_t rdFlags;
	logic       wEdReg;
	logic       csrWrite;
	logic       flagClear;

	assign csrWrite  = csrCmd.cke && csrCmd.write;
	assign flagClear = csrWrite && csrCmd.adrs == `MCB_CSR_RD_FLAGS;

	//----------------------------------------------------------
	// Registers, write pulse and slave capture
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			busAdrsReg <= '0;
			busWdReg   <= '0;
			scratchReg <= '0;
			autoRdReg  <= '0;
			rdFlags    <= '0;
			wEdReg     <= 1'b0;
			csrRd      <= '0;
		end
		else
		begin
			wEdReg <= csrWrite && csrCmd.adrs == `MCB_CSR_BUS_WD;
			if (csrWrite && csrCmd.adrs == `MCB_CSR_BUS_ADRS)
				busAdrsReg <= csrCmd.wd[`MCB_BUS_ADRS_BITS-1:0];
			if (csrWrite && csrCmd.adrs == `MCB_CSR_BUS_WD)
				busWdReg <= csrCmd.wd;
			if (csrWrite && csrCmd.adrs == `MCB_CSR_SCRATCH)
				scratchReg <= csrCmd.wd;
			// Any slave read enable captures the word
			if (|muREd)
				autoRdReg <= muRd;
			// Fresh capture bits survive a clear
			rdFlags <= (flagClear ? '0 : rdFlags) | muREd;
			// Registered readback mux
			if (csrCmd.cke && !csrCmd.write)
			begin
				case (csrCmd.adrs)
					`MCB_CSR_BUS_ADRS:
						csrRd <= {{(`MCB_BUS_DATA_BITS-`MCB_BUS_ADRS_BITS){1'b0}}, busAdrsReg};
					`MCB_CSR_BUS_WD:   csrRd <= busWdReg;
					`MCB_CSR_SCRATCH:  csrRd <= scratchReg;
					`MCB_CSR_AUTO_RD:  csrRd <= autoRdReg;
					`MCB_CSR_RD_FLAGS:
						csrRd <= {{(`MCB_BUS_DATA_BITS-`MCB_SLAVES){1'b0}}, rdFlags};
					default:           csrRd <= '0;
				endcase
			end
		end
	end

	assign busWr.wd   = busWdReg;
	assign busWr.adrs = busAdrsReg;
	assign busWr.wEd  = wEdReg;

endmodule

`default_nettype wire

// File: hdl/MicroControllerBlock.sv
// Bus master top, host access over UART
// Hardware command parser replaces the soft-core CPU
// Reply start time depends on transmitter busy, not fixed

`timescale 1ns/100ps
`default_nettype none

module MicroControllerBlock (
	input  logic               uartRx,
	output logic               uartTx,
	input  McbPkg::busData_t   muRd,
	input  McbPkg::slaveMask_t muREd,
	output McbPkg::busWrite_t  busWr,
	input  logic               sysClk,
	input  logic               reset
);
	import McbPkg::*;

	//----------------------------------------------------------
	// Internal links
	//----------------------------------------------------------
	uartByte_t rxByte;
	logic      rxValid;
	csrCmd_t   csrCmd;
	busData_t  csrRd;
	uartByte_t txByte;
	logic      txStart;
	logic      txBusy;

	// Input side
	UartRx uartRxInst (
		.sysClk  (sysClk),
		.reset   (reset),
		.rx      (uartRx),
		.rxByte  (rxByte),
		.rxValid (rxValid)
	);

	// Command frames to CSR accesses and replies
	McbCommandParser parserInst (
		.sysClk  (sysClk),
		.reset   (reset),
		.rxByte  (rxByte),
		.rxValid (rxValid),
		.csrCmd  (csrCmd),
		.csrRd   (csrRd),
		.txByte  (txByte),
		.txStart (txStart),
		.txBusy  (txBusy)
	);

	// CSR space and bus master
	MicroControllerCsr csrInst (
		.sysClk (sysClk),
		.reset  (reset),
		.csrCmd (csrCmd),
		.csrRd  (csrRd),
		.muRd   (muRd),
		.muREd  (muREd),
		.busWr  (busWr)
	);

	// Output side
	UartTx uartTxInst (
		.sysClk  (sysClk),
		.reset   (reset),
		.txByte  (txByte),
		.txStart (txStart),
		.tx      (uartTx),
		.txBusy  (txBusy)
	);

endmodule

`default_nettype wire

// File: test/McbTb.sv
// Testbench for the UART-controlled bus master
// Host frames are driven bit by bit on the falling clock edge
// Reply bytes are collected by a line monitor, stops at the first error
// Random data uses a fixed seed

`timescale 1ns/100ps
`default_nettype none

`include "mcb_consts.svh"

module McbTb;
	import McbPkg::*;

	localparam int numCommands = 10;
	localparam longint watchdogNs = numCommands * 11 * 10 * `MCB_CLKS_PER_BIT * 100 * 2;
	// Generous gap for one reply byte
	localparam int replyWaitCycles = 3 * 10 * `MCB_CLKS_PER_BIT;

	logic       sysClk;
	logic       reset;
	logic       uartRx;
	logic       uartTx;
	busData_t   muRd;
	slaveMask_t muREd;
	busWrite_t  busWr;

	// Expected bus write, set before a BUS_WD write
	logic       wrExpected;
	busAdrs_t   expAdrs;
	busData_t   expWd;
	int         pulseCount;
	int         seed;
	uartByte_t  replyQueue[$];

	MicroControllerBlock uut (
		.uartRx (uartRx),
		.uartTx (uartTx),
		.muRd   (muRd),
		.muREd  (muREd),
		.busWr  (busWr),
		.sysClk (sysClk),
		.reset  (reset)
	);

	initial
	begin
		sysClk = 1'b0;
		forever #50 sysClk = ~sysClk;
	end

	task automatic abortRun;
		$display("tests failed");
		$fatal(1, "Stopping at first error");
	endtask

	//------------------------------------------------------------
	// Bus write pulse checks
	//------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
			pulseCount <= 0;
		else if (busWr.wEd)
			pulseCount <= pulseCount + 1;
	end

	assert property (@(posedge sysClk) disable iff (reset) busWr.wEd |=> !busWr.wEd)
	else
	begin
		$display("ERROR at %0t: busWr.wEd expected 0 got 1", $time);
		abortRun();
	end

	// Only while a BUS_WD write is in flight
	assert property (@(posedge sysClk) disable iff (reset) busWr.wEd |-> wrExpected)
	else
	begin
		$display("ERROR at %0t: busWr.wEd expected 0 got 1", $time);
		abortRun();
	end

	assert property (@(posedge sysClk) disable iff (reset) busWr.wEd |-> busWr.adrs == expAdrs)
	else
	begin
		$display("ERROR at %0t: busWr.adrs expected %h got %h",
			$time, $sampled(expAdrs), $sampled(busWr.adrs));
		abortRun();
	end

	assert property (@(posedge sysClk) disable iff (reset) busWr.wEd |-> busWr.wd == expWd)
	else
	begin
		$display("ERROR at %0t: busWr.wd expected %h got %h",
			$time, $sampled(expWd), $sampled(busWr.wd));
		abortRun();
	end

	//------------------------------------------------------------
	// Reply line monitor, samples at mid-bit
	//------------------------------------------------------------
	initial
	begin : txMonitor
		uartByte_t b;
		logic prevTx;
		int i;
		prevTx = 1'b1;
		forever
		begin
			@(negedge sysClk);
			if (prevTx === 1'b1 && uartTx === 1'b0 && !reset)
			begin
				repeat (`MCB_CLKS_PER_BIT / 2) @(negedge sysClk);
				assert (uartTx === 1'b0)
				else
				begin
					$display("Start bit on uartTx did not last to mid-bit at %0t", $time);
					abortRun();
				end
				for (i = 0; i < 8; i++)
				begin
					repeat (`MCB_CLKS_PER_BIT) @(negedge sysClk);
					b[i] = uartTx;
				end
				repeat (`MCB_CLKS_PER_BIT) @(negedge sysClk);
				assert (uartTx === 1'b1)
				else
				begin
					$display("Missing stop bit on uartTx at %0t", $time);
					abortRun();
				end
				replyQueue.push_back(b);
			end
			prevTx = uartTx;
		end
	end

	//------------------------------------------------------------
	// Host tasks
	//------------------------------------------------------------
	task automatic sendByte(input uartByte_t b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			@(negedge sysClk);
			uartRx = frame[i];
			repeat (`MCB_CLKS_PER_BIT - 1) @(negedge sysClk);
		end
	endtask

	task automatic recvByte(input uartByte_t expected, input string what);
		int waited;
		uartByte_t got;
		waited = 0;
		while (replyQueue.size() == 0 && waited < replyWaitCycles)
		begin
			@(negedge sysClk);
			waited++;
		end
		if (replyQueue.size() == 0)
		begin
			$display("No %s byte came back from the DUT by %0t", what, $time);
			abortRun();
		end
		else
		begin
			got = replyQueue.pop_front();
			assert (got == expected)
			else
			begin
				$display("ERROR at %0t: uartTx %s expected %h got %h", $time, what, expected, got);
				abortRun();
			end
		end
	endtask

	// 'W', address, 4 data bytes MSB first, answered by 'K'
	task automatic sendWrite(input csrAdrs_t adrs, input busData_t data);
		int i;
		sendByte(`MCB_CMD_WRITE);
		sendByte(adrs);
		for (i = 3; i >= 0; i--)
			sendByte(data[8*i +: 8]);
		recvByte(`MCB_REPLY_ACK, "write ack");
	endtask

	// 'R', address, reply is the CSR word MSB first
	task automatic sendRead(input csrAdrs_t adrs, input busData_t expected);
		int i;
		sendByte(`MCB_CMD_READ);
		sendByte(adrs);
		for (i = 3; i >= 0; i--)
			recvByte(expected[8*i +: 8], "read data");
	endtask

	task automatic pulseSlave(input slaveMask_t mask, input busData_t data);
		@(negedge sysClk);
		muRd  = data;
		muREd = mask;
		@(negedge sysClk);
		muRd  = '0;
		muREd = '0;
	endtask

	task automatic checkCount(input int expected);
		assert (pulseCount == expected)
		else
		begin
			$display("ERROR at %0t: busWr.wEd pulse count expected %0d got %0d",
				$time, expected, pulseCount);
			abortRun();
		end
	endtask

	initial
	begin : watchdog
		#(watchdogNs);
		$display("Run did not finish within %0d ns, DUT appears stuck", watchdogNs);
		abortRun();
	end

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------
	initial
	begin : mainSeq
		busData_t   adrsVal;
		busData_t   wdVal;
		busData_t   scratchVal;
		busData_t   data1;
		busData_t   data2;
		slaveMask_t mask1;
		slaveMask_t mask2;
		int i;
		seed       = 6530;
		reset      = 1'b1;
		uartRx     = 1'b1;
		muRd       = '0;
		muREd      = '0;
		wrExpected = 1'b0;
		expAdrs    = '0;
		expWd      = '0;
		repeat (2) @(negedge sysClk);
		reset = 1'b0;

		// Quiet outputs before any command
		for (i = 0; i < 2 * `MCB_CLKS_PER_BIT; i++)
		begin
			@(negedge sysClk);
			assert (uartTx === 1'b1 && busWr.wEd === 1'b0)
			else
			begin
				$display("ERROR at %0t: uartTx/busWr.wEd expected 1/0 got %b/%b",
					$time, uartTx, busWr.wEd);
				abortRun();
			end
		end

		// Address write alone, no pulse
		adrsVal = $random(seed);
		wdVal   = $random(seed);
		sendWrite(`MCB_CSR_BUS_ADRS, adrsVal);
		checkCount(0);

		// Data write fires exactly one pulse
		expAdrs    = adrsVal[`MCB_BUS_ADRS_BITS-1:0];
		expWd      = wdVal;
		wrExpected = 1'b1;
		sendWrite(`MCB_CSR_BUS_WD, wdVal);
		wrExpected = 1'b0;
		checkCount(1);

		// Scratch round trip
		scratchVal = $random(seed);
		sendWrite(`MCB_CSR_SCRATCH, scratchVal);
		sendRead(`MCB_CSR_SCRATCH, scratchVal);
		checkCount(1);

		// Two slave pushes, last word wins, flags accumulate
		data1 = $random(seed);
		data2 = $random(seed);
		mask1 = $random(seed);
		mask2 = $random(seed);
		if (mask1 == '0)
			mask1 = 1;
		if (mask2 == '0)
			mask2 = 1;
		pulseSlave(mask1, data1);
		pulseSlave(mask2, data2);
		sendRead(`MCB_CSR_AUTO_RD, data2);
		sendRead(`MCB_CSR_RD_FLAGS, busData_t'(mask1 | mask2));
		sendWrite(`MCB_CSR_RD_FLAGS, '0);
		sendRead(`MCB_CSR_RD_FLAGS, '0);

		// Unknown opcode, then a normal read
		sendByte(8'h3F);
		recvByte(`MCB_REPLY_ERR, "error reply");
		sendRead(`MCB_CSR_SCRATCH, scratchVal);
		checkCount(1);

		repeat (4 * `MCB_CLKS_PER_BIT) @(negedge sysClk);
		if (replyQueue.size() != 0)
		begin
			$display("DUT sent %0d reply bytes that no command asked for", replyQueue.size());
			abortRun();
		end
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/McbPkg.sv
hdl/UartRx.sv
hdl/UartTx.sv
hdl/McbCommandParser.sv
hdl/MicroControllerCsr.sv
hdl/MicroControllerBlock.sv
test/McbTb.sv

// File: Bender.yml
package:
  name: mcb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/McbPkg.sv
      - hdl/UartRx.sv
      - hdl/UartTx.sv
      - hdl/McbCommandParser.sv
      - hdl/MicroControllerCsr.sv
      - hdl/MicroControllerBlock.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/McbTb.sv
